//--- list.f
design/ls_pkg.sv
design/lane_enable_decoder.sv
design/act_distributor.sv
design/ls_lane.sv
design/result_collector.sv
design/ls_array.sv
tests/ls_array_chk.sv
tests/tb_ls_array.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ls_array \
    -f list.f -o tb_ls_array > build.log 2>&1 &&
./obj_dir/tb_ls_array > sim.log 2>&1 ||
echo "build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && exit 0 || exit 1

//--- tests/tb_ls_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ls_array;

    localparam int COLUMNS = 8;
    localparam int TIMEOUT_CYCLES = 4000;

    typedef ls_pkg::word_t [COLUMNS-1:0] vec_t;

    logic               clk;
    logic               reset;
    logic               enable;
    ls_pkg::precision_e precision;
    logic               act_valid;
    ls_pkg::word_t      act_data;
    logic               act_ready;
    logic               mxu_act_valid;
    vec_t               mxu_act_data;
    logic               mxu_act_ready;
    logic               mxu_res_valid;
    vec_t               mxu_res_data;
    logic               mxu_res_ready;
    logic               res_valid;
    ls_pkg::word_t      res_data;
    logic               res_ready;

    logic [31:0]   rng;
    int            value_errors;
    int            other_errors;
    ls_pkg::word_t pending_q[$];
    vec_t          vec_q[$];
    ls_pkg::word_t word_q[$];

    ls_array #(.COLUMNS(COLUMNS)) dut_i (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .precision     (precision),
        .act_valid     (act_valid),
        .act_data      (act_data),
        .act_ready     (act_ready),
        .mxu_act_valid (mxu_act_valid),
        .mxu_act_data  (mxu_act_data),
        .mxu_act_ready (mxu_act_ready),
        .mxu_res_valid (mxu_res_valid),
        .mxu_res_data  (mxu_res_data),
        .mxu_res_ready (mxu_res_ready),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_ready     (res_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////
    // random source and model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic ls_pkg::word_t rand_word();
        ls_pkg::word_t w;
        w[63:32] = next_rand();
        w[31:0]  = next_rand();
        return w;
    endfunction

    // lanes in use = COLUMNS * precision bits / 64
    function automatic int lanes_for(input ls_pkg::precision_e p);
        int bits;
        case (p)
            ls_pkg::INT8:  bits = 8;
            ls_pkg::INT16: bits = 16;
            ls_pkg::INT32: bits = 32;
            default:       bits = 64;
        endcase
        return COLUMNS * bits / 64;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input ls_pkg::word_t exp,
                              input ls_pkg::word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_vec(input string name, input vec_t exp, input vec_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idle_outputs(input string name);
        check_flag({name, " act_ready"}, 1'b0, act_ready);
        check_flag({name, " mxu_act_valid"}, 1'b0, mxu_act_valid);
        check_flag({name, " mxu_res_ready"}, 1'b0, mxu_res_ready);
        check_flag({name, " res_valid"}, 1'b0, res_valid);
    endtask

    //////////////////////////////
    // traffic phase
    //////////////////////////////

    // both streams run at once, one loop iteration per clock
    task automatic run_phase(input string name, input ls_pkg::precision_e p,
                             input int vectors, input bit stress);
        int   n;
        int   words_offered;
        int   vecs_offered;
        int   vecs_issued;
        int   words_out;
        int   cycles;
        bit   act_fire;
        bit   mxu_fire;
        bit   res_in_fire;
        bit   res_fire;
        bit   expect_issue;
        bit   expect_drain;
        vec_t vec;

        n = lanes_for(p);
        words_offered = 0;
        vecs_offered = 0;
        vecs_issued = 0;
        words_out = 0;
        cycles = 0;
        act_fire = 1'b0;
        res_in_fire = 1'b0;
        expect_issue = 1'b0;
        expect_drain = 1'b0;

        // decoder needs a cycle to pick up the new lane count
        precision = p;
        @(negedge clk);
        @(negedge clk);

        while (!(vecs_issued == vectors && words_out == vectors * n)
               && cycles < TIMEOUT_CYCLES) begin
            if (act_fire) begin
                act_valid = 1'b0;
            end
            if (!act_valid && words_offered < vectors * n
                && (!stress || (next_rand() % 4) != 0)) begin
                act_valid = 1'b1;
                act_data = rand_word();
                words_offered++;
            end
            if (res_in_fire) begin
                mxu_res_valid = 1'b0;
            end
            if (!mxu_res_valid && vecs_offered < vectors
                && (!stress || (next_rand() % 3) == 0)) begin
                mxu_res_valid = 1'b1;
                for (int i = 0; i < COLUMNS; i++) begin
                    mxu_res_data[i] = rand_word();
                end
                vecs_offered++;
            end
            mxu_act_ready = !stress || (next_rand() % 2) == 1;
            res_ready = !stress || (next_rand() % 4) != 0;

            #1;
            // one cycle from last word to vector, and from result to first word
            if (expect_issue) begin
                check_flag({name, " vector latency"}, 1'b1, mxu_act_valid);
            end
            if (expect_drain) begin
                check_flag({name, " drain latency"}, 1'b1, res_valid);
            end
            act_fire = act_valid && act_ready;
            mxu_fire = mxu_act_valid && mxu_act_ready;
            res_in_fire = mxu_res_valid && mxu_res_ready;
            res_fire = res_valid && res_ready;
            expect_issue = 1'b0;
            expect_drain = res_in_fire;

            if (act_fire) begin
                pending_q.push_back(act_data);
                if (pending_q.size() == n) begin
                    vec = '0;
                    for (int i = 0; i < n; i++) begin
                        vec[i] = pending_q[i];
                    end
                    vec_q.push_back(vec);
                    pending_q.delete();
                    expect_issue = 1'b1;
                end
            end
            if (mxu_fire) begin
                if (vec_q.size() == 0) begin
                    other_errors++;
                    $display("%s: vector issued before all its words arrived", name);
                end else begin
                    check_vec({name, " activation vector"}, vec_q.pop_front(), mxu_act_data);
                end
                vecs_issued++;
            end
            if (res_in_fire) begin
                for (int i = 0; i < n; i++) begin
                    word_q.push_back(mxu_res_data[i]);
                end
            end
            if (res_fire) begin
                if (word_q.size() == 0) begin
                    other_errors++;
                    $display("%s: output word emitted with none expected", name);
                end else begin
                    check_word({name, " output word"}, word_q.pop_front(), res_data);
                end
                words_out++;
            end

            @(negedge clk);
            cycles++;
        end

        act_valid = 1'b0;
        mxu_res_valid = 1'b0;
        mxu_act_ready = 1'b0;
        res_ready = 1'b0;
        if (cycles >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("%s: timed out waiting for the streams to finish", name);
        end
        if (pending_q.size() != 0 || vec_q.size() != 0 || word_q.size() != 0) begin
            other_errors++;
            $display("%s: words left over in the model after the phase", name);
        end
        pending_q.delete();
        vec_q.delete();
        word_q.delete();
        check_flag({name, " mxu_act_valid at end"}, 1'b0, mxu_act_valid);
        check_flag({name, " res_valid at end"}, 1'b0, res_valid);
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        rng = 32'h7ec6_7b7f;
        value_errors = 0;
        other_errors = 0;
        reset = 1'b1;
        enable = 1'b0;
        precision = ls_pkg::INT8;
        act_valid = 1'b0;
        act_data = '0;
        mxu_act_ready = 1'b0;
        mxu_res_valid = 1'b0;
        mxu_res_data = '0;
        res_ready = 1'b0;

        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs("enable low");
        end

        enable = 1'b1;
        run_phase("int8 plain", ls_pkg::INT8, 3, 1'b0);
        run_phase("int16 plain", ls_pkg::INT16, 3, 1'b0);
        run_phase("int32 plain", ls_pkg::INT32, 3, 1'b0);
        run_phase("int64 plain", ls_pkg::INT64, 3, 1'b0);
        // precision walk under random gaps and back-pressure
        run_phase("int64 random", ls_pkg::INT64, 20, 1'b1);
        run_phase("int8 random", ls_pkg::INT8, 20, 1'b1);
        run_phase("int32 random", ls_pkg::INT32, 20, 1'b1);
        run_phase("int16 random", ls_pkg::INT16, 20, 1'b1);

        enable = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("enable dropped");
        end

        $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ls_array_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ls_array_chk #(
    parameter int COLUMNS = 8
) (
    input wire                              clk,
    input wire                              reset,
    input wire                              enable,
    input wire                              act_ready,
    input wire                              mxu_act_valid,
    input wire                              mxu_act_ready,
    input wire ls_pkg::word_t [COLUMNS-1:0] mxu_act_data,
    input wire                              mxu_res_ready,
    input wire                              res_valid,
    input wire                              res_ready,
    input wire ls_pkg::word_t               res_data
);

    // vector to the matrix unit holds until it is taken
    a_mxu_act_hold: assert property (@(posedge clk) disable iff (reset)
        mxu_act_valid && !mxu_act_ready |=> mxu_act_valid && $stable(mxu_act_data))
        else $error("activation vector dropped or changed before its transfer");

    // output word holds until it is taken
    a_res_hold: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else $error("output word dropped or changed before its transfer");

    // registered run follows enable one cycle later
    a_idle_when_stopped: assert property (@(posedge clk) disable iff (reset)
        !enable |=> !act_ready && !mxu_res_ready)
        else $error("input side ready while the array is not running");

    // collector takes a new vector only when drained
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(res_valid && mxu_res_ready))
        else $error("collector ready for a result while still draining");

endmodule

bind ls_array ls_array_chk #(.COLUMNS(COLUMNS)) chk_i (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .act_ready     (act_ready),
    .mxu_act_valid (mxu_act_valid),
    .mxu_act_ready (mxu_act_ready),
    .mxu_act_data  (mxu_act_data),
    .mxu_res_ready (mxu_res_ready),
    .res_valid     (res_valid),
    .res_ready     (res_ready),
    .res_data      (res_data)
);

`default_nettype wire

//--- design/ls_array.sv
`timescale 1ns/1ps
`default_nettype none

module ls_array #(
    parameter int COLUMNS = 8
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                enable,
    input  wire ls_pkg::precision_e            precision,

    // activation stream in
    input  wire                                act_valid,
    input  wire ls_pkg::word_t                 act_data,
    output logic                               act_ready,

    // activation vector to the matrix unit
    output logic                               mxu_act_valid,
    output ls_pkg::word_t [COLUMNS-1:0]        mxu_act_data,
    input  wire                                mxu_act_ready,

    // result vector from the matrix unit
    input  wire                                mxu_res_valid,
    input  wire ls_pkg::word_t [COLUMNS-1:0]   mxu_res_data,
    output logic                               mxu_res_ready,

    // result stream out
    output logic                               res_valid,
    output ls_pkg::word_t                      res_data,
    input  wire                                res_ready
);

    logic                              run;
    logic [COLUMNS-1:0]                lane_en;
    ls_pkg::lane_cnt_t                 active_lanes;
    ls_pkg::lane_load_t [COLUMNS-1:0]  lane_load;
    logic                              load_clear;
    ls_pkg::lane_store_t [COLUMNS-1:0] lane_store;
    ls_pkg::word_t [COLUMNS-1:0]       store_word;

    lane_enable_decoder #(.COLUMNS(COLUMNS)) decoder_i (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .precision    (precision),
        .lane_en      (lane_en),
        .active_lanes (active_lanes),
        .run          (run)
    );

    act_distributor #(.COLUMNS(COLUMNS)) distributor_i (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .active_lanes  (active_lanes),
        .act_valid     (act_valid),
        .act_data      (act_data),
        .act_ready     (act_ready),
        .lane_load     (lane_load),
        .load_clear    (load_clear),
        .mxu_act_valid (mxu_act_valid),
        .mxu_act_ready (mxu_act_ready)
    );

    ///////////////////////////////
    // lanes
    ///////////////////////////////

    // load side feeds the matrix unit directly, store side goes to the collector
    for (genvar j = 0; j < COLUMNS; j++) begin : g_lane
        ls_lane lane_i (
            .clk        (clk),
            .reset      (reset),
            .lane_en    (lane_en[j]),
            .lane_load  (lane_load[j]),
            .load_clear (load_clear),
            .lane_store (lane_store[j]),
            .load_word  (mxu_act_data[j]),
            .store_word (store_word[j])
        );
    end

    result_collector #(.COLUMNS(COLUMNS)) collector_i (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .active_lanes  (active_lanes),
        .mxu_res_valid (mxu_res_valid),
        .mxu_res_data  (mxu_res_data),
        .mxu_res_ready (mxu_res_ready),
        .lane_store    (lane_store),
        .store_word    (store_word),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_ready     (res_ready)
    );

endmodule

`default_nettype wire

//--- design/result_collector.sv
`timescale 1ns/1ps
`default_nettype none

module result_collector #(
    parameter int COLUMNS = 8
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               run,
    input  wire ls_pkg::lane_cnt_t            active_lanes,
    input  wire                               mxu_res_valid,
    input  wire ls_pkg::word_t [COLUMNS-1:0]  mxu_res_data,
    output logic                              mxu_res_ready,
    output ls_pkg::lane_store_t [COLUMNS-1:0] lane_store,
    input  wire ls_pkg::word_t [COLUMNS-1:0]  store_word,
    output logic                              res_valid,
    output ls_pkg::word_t                     res_data,
    input  wire                               res_ready
);

    ls_pkg::coll_state_e state;
    ls_pkg::lane_idx_t   drain_cnt;
    logic                vec_accept;
    logic                word_xfer;
    logic                last_lane;

    ///////////////////////////////
    // handshakes
    ///////////////////////////////

    assign mxu_res_ready = (state == ls_pkg::IDLE) && run;
    assign vec_accept    = mxu_res_valid && mxu_res_ready;
    assign res_valid     = (state == ls_pkg::DRAIN);
    assign word_xfer     = res_valid && res_ready;

    assign last_lane = (ls_pkg::lane_cnt_t'(drain_cnt) == active_lanes - ls_pkg::lane_cnt_t'(1));

    // every lane is strobed, inactive lanes drop the write themselves
    always_comb begin
        for (int i = 0; i < COLUMNS; i++) begin
            lane_store[i].wr   = vec_accept;
            lane_store[i].data = mxu_res_data[i];
        end
    end

    ///////////////////////////////
    // output mux
    ///////////////////////////////

    // drain counter selects the lane on the output stream
    assign res_data = store_word[drain_cnt];

    ///////////////////////////////
    // drain FSM
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ls_pkg::IDLE;
            drain_cnt <= '0;
        end else begin
            case (state)
                ls_pkg::IDLE: begin
                    if (vec_accept) begin
                        drain_cnt <= '0;
                        state     <= ls_pkg::DRAIN;
                    end
                end
                ls_pkg::DRAIN: begin
                    // one lane per transfer, stall while res_ready is low
                    if (word_xfer) begin
                        if (last_lane) begin
                            drain_cnt <= '0;
                            state     <= ls_pkg::IDLE;
                        end else begin
                            drain_cnt <= drain_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ls_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/ls_lane.sv
`timescale 1ns/1ps
`default_nettype none

module ls_lane (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      lane_en,
    input  wire ls_pkg::lane_load_t  lane_load,
    input  wire                      load_clear,
    input  wire ls_pkg::lane_store_t lane_store,
    output ls_pkg::word_t            load_word,
    output ls_pkg::word_t            store_word
);

    ls_pkg::word_t load_q;
    ls_pkg::word_t store_q;

    ///////////////////////////////
    // load side
    ///////////////////////////////

    // cleared after every issued vector
    always_ff @(posedge clk) begin
        if (reset || load_clear) begin
            load_q <= '0;
        end else if (lane_en && lane_load.wr) begin
            load_q <= lane_load.data;
        end
    end

    ///////////////////////////////
    // store side
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (lane_en && lane_store.wr) begin
            store_q <= lane_store.data;
        end
    end

    // a disabled lane reads as zero on both sides
    assign load_word  = lane_en ? load_q : '0;
    assign store_word = lane_en ? store_q : '0;

endmodule

`default_nettype wire

//--- design/act_distributor.sv
`timescale 1ns/1ps
`default_nettype none

module act_distributor #(
    parameter int COLUMNS = 8
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              run,
    input  wire ls_pkg::lane_cnt_t           active_lanes,
    input  wire                              act_valid,
    input  wire ls_pkg::word_t               act_data,
    output logic                             act_ready,
    output ls_pkg::lane_load_t [COLUMNS-1:0] lane_load,
    output logic                             load_clear,
    output logic                             mxu_act_valid,
    input  wire                              mxu_act_ready
);

    ls_pkg::dist_state_e state;
    ls_pkg::lane_idx_t   fill_cnt;
    logic                act_accept;
    logic                last_lane;

    ///////////////////////////////
    // handshakes
    ///////////////////////////////

    assign act_ready     = (state == ls_pkg::FILL) && run;
    assign act_accept    = act_valid && act_ready;
    assign mxu_act_valid = (state == ls_pkg::ISSUE);

    // vector taken by the matrix unit, empty the lanes for the next fill
    assign load_clear = mxu_act_valid && mxu_act_ready;

    assign last_lane = (ls_pkg::lane_cnt_t'(fill_cnt) == active_lanes - ls_pkg::lane_cnt_t'(1));

    ///////////////////////////////
    // inverse mux
    ///////////////////////////////

    // only the lane under the fill counter sees a write strobe
    always_comb begin
        for (int i = 0; i < COLUMNS; i++) begin
            lane_load[i].wr   = act_accept && (fill_cnt == ls_pkg::lane_idx_t'(i));
            lane_load[i].data = act_data;
        end
    end

    ///////////////////////////////
    // fill FSM
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ls_pkg::FILL;
            fill_cnt <= '0;
        end else begin
            case (state)
                ls_pkg::FILL: begin
                    if (act_accept) begin
                        if (last_lane) begin
                            fill_cnt <= '0;
                            state    <= ls_pkg::ISSUE;
                        end else begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                    end
                end
                ls_pkg::ISSUE: begin
                    // hold here while the matrix unit stalls, input stays blocked
                    if (load_clear) begin
                        state <= ls_pkg::FILL;
                    end
                end
                default: begin
                    state <= ls_pkg::FILL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/lane_enable_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// COLUMNS is expected to be a multiple of 8, otherwise int8 maps to zero lanes
module lane_enable_decoder #(
    parameter int COLUMNS = 8
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     enable,
    input  wire ls_pkg::precision_e precision,
    output logic [COLUMNS-1:0]      lane_en,
    output ls_pkg::lane_cnt_t       active_lanes,
    output logic                    run
);

    ls_pkg::lane_cnt_t  count_next;
    logic [COLUMNS-1:0] mask_next;

    // active lanes = COLUMNS * precision bits / word bits
    always_comb begin
        count_next = '0;
        if (enable) begin
            count_next = ls_pkg::lane_cnt_t'((COLUMNS * (8 << precision)) / ls_pkg::WORD_BITS);
        end
        // thermometer mask over the low lanes
        for (int i = 0; i < COLUMNS; i++) begin
            mask_next[i] = (i < int'(count_next));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run          <= 1'b0;
            lane_en      <= '0;
            active_lanes <= '0;
        end else begin
            run          <= enable;
            lane_en      <= mask_next;
            active_lanes <= count_next;
        end
    end

endmodule

`default_nettype wire

//--- design/ls_pkg.sv
`default_nettype none

package ls_pkg;

    ///////////////////////////////
    // widths
    ///////////////////////////////

    // the precision decode assumes a 64 bit word
    localparam int WORD_BITS = 64;

    // largest lane count the counters can address
    localparam int MAX_COLUMNS = 32;

    typedef logic [WORD_BITS-1:0] word_t;

    // 0 .. MAX_COLUMNS inclusive
    typedef logic [$clog2(MAX_COLUMNS):0] lane_cnt_t;

    typedef logic [$clog2(MAX_COLUMNS)-1:0] lane_idx_t;

    ///////////////////////////////
    // encodings
    ///////////////////////////////

    typedef enum logic [1:0] {
        INT8  = 2'd0,
        INT16 = 2'd1,
        INT32 = 2'd2,
        INT64 = 2'd3
    } precision_e;

    // distributor to lane, write one activation word
    typedef struct packed {
        logic  wr;
        word_t data;
    } lane_load_t;

    // collector to lane, write one result word
    typedef struct packed {
        logic  wr;
        word_t data;
    } lane_store_t;

    typedef enum logic {FILL, ISSUE} dist_state_e;

    typedef enum logic {IDLE, DRAIN} coll_state_e;

endpackage

`default_nettype wire
